// ==== run_sim.sh ====
#!/bin/sh
# Build the controller and testbench with Verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_dram_ctrl \
    && ./obj_dir/Vtb_dram_ctrl > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// ==== src/bank_tracker.sv ====
// Per-bank open row table and row hit, conflict or closed classification
`timescale 1ns/10ps

module bank_tracker (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic [dram_pkg::BANK_BITS-1:0] bank,      // Flat {bg, ba}
    input  logic [dram_pkg::ROW_BITS-1:0]  row,
    input  logic                          open,      // ACT to bank with row
    input  logic                          close,     // PRE to bank
    input  logic                          close_all, // PREA
    output dram_pkg::row_state_e          row_state
);

    import dram_pkg::*;

    logic [NUM_BANKS-1:0] open_q;                  // One flag per bank
    logic [ROW_BITS-1:0]  open_row_q [NUM_BANKS];  // Row held in each sense amp

    // ------------------------------
    // Bank open flags
    // ------------------------------
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open_q <= '0;  // All banks closed
        end else if (close_all) begin
            open_q <= '0;
        end else begin
            if (close) begin
                open_q[bank] <= 1'b0;
            end
            if (open) begin
                open_q[bank] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (open) begin
            open_row_q[bank] <= row;
        end
    end

    // Classify the presented address
    always_comb begin
        if (!open_q[bank]) begin
            row_state = BANK_CLOSED;
        end else if (open_row_q[bank] == row) begin
            row_state = ROW_HIT;
        end else begin
            row_state = ROW_CONFLICT;
        end
    end

    a_act_closed : assert property (@(posedge clk_in) disable iff (rst_in) open |-> !open_q[bank])
        else $error("ACT to a bank that is already open");
    a_pre_open : assert property (@(posedge clk_in) disable iff (rst_in) close |-> open_q[bank])
        else $error("PRE to a bank that is not open");

endmodule : bank_tracker

// ==== src/cmd_fsm.sv ====
// Command FSM with address split, latency sequencing, refresh and DIMM pin encoding
`timescale 1ns/10ps

module cmd_fsm (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  dram_pkg::mem_req_t             req_head,   // Request in service
    input  logic                           req_empty,
    input  logic                           rsp_full,
    input  dram_pkg::row_state_e           row_state,
    input  logic                           timer_done,
    input  logic                           refresh_due,
    input  logic [dram_pkg::DATA_BITS-1:0]  dq_in,
    output logic                           req_deq,
    output logic                           rsp_enq,
    output dram_pkg::mem_rsp_t             rsp_data,
    output logic [dram_pkg::BANK_BITS-1:0]  bank,       // To bank tracker
    output logic [dram_pkg::ROW_BITS-1:0]   row,
    output logic                           open,
    output logic                           close,
    output logic                           close_all,
    output logic                           load,       // To timer
    output logic [dram_pkg::TIMER_BITS-1:0] count,
    output logic                           refresh_ack,
    output dram_pkg::dram_pins_t           pins,
    output logic [dram_pkg::DATA_BITS-1:0]  dq_out,
    output logic                           dq_oe
);

    import dram_pkg::*;

    typedef enum logic [2:0] {
        IDLE,       // Pick next command
        PRECHARGE,  // Wait T_RP after PRE
        ACTIVATE,   // Wait T_RCD after ACT
        ACCESS,     // Issue RD or WR
        WAIT_CAS,   // Wait for read data
        REFRESH     // PREA, then REF
    } state_e;

    state_e                state_q, state_d;
    dram_cmd_e             cmd;         // Command on the pins this cycle
    logic [COL_BITS-1:0]   col;
    logic [BA_BITS-1:0]    ba;
    logic [BG_BITS-1:0]    bg;
    logic                  ref_sent_q;  // REF already out in REFRESH
    logic                  cas_hit;     // Read data on dq_in now
    logic                  push_q;
    logic [PADDR_BITS-1:0] rsp_addr_q;
    logic [DATA_BITS-1:0]  rdata_q;

    // Column lowest, then bank, bank group, row
    assign col  = req_head.addr[COL_BITS-1:0];
    assign ba   = req_head.addr[COL_BITS +: BA_BITS];
    assign bg   = req_head.addr[COL_BITS + BA_BITS +: BG_BITS];
    assign row  = req_head.addr[COL_BITS + BANK_BITS +: ROW_BITS];
    assign bank = {bg, ba};

    // ------------------------------
    // Next state and strobes
    // ------------------------------
    always_comb begin
        state_d     = state_q;
        cmd         = NOP;
        req_deq     = 1'b0;
        open        = 1'b0;
        close       = 1'b0;
        close_all   = 1'b0;
        load        = 1'b0;
        count       = '0;
        refresh_ack = 1'b0;
        dq_oe       = 1'b0;
        case (state_q)
            IDLE: begin
                if (refresh_due) begin  // Refresh only between requests
                    cmd         = PREA;
                    close_all   = 1'b1;
                    refresh_ack = 1'b1;
                    load        = 1'b1;
                    count       = TIMER_BITS'(T_RP);
                    state_d     = REFRESH;
                end else if (!req_empty) begin
                    case (row_state)
                        ROW_HIT: state_d = ACCESS;
                        ROW_CONFLICT: begin
                            cmd     = PRE;
                            close   = 1'b1;
                            load    = 1'b1;
                            count   = TIMER_BITS'(T_RP);
                            state_d = PRECHARGE;
                        end
                        default: begin  // Bank closed
                            cmd     = ACT;
                            open    = 1'b1;
                            load    = 1'b1;
                            count   = TIMER_BITS'(T_RCD);
                            state_d = ACTIVATE;
                        end
                    endcase
                end
            end
            PRECHARGE: begin
                if (timer_done) begin
                    cmd     = ACT;
                    open    = 1'b1;
                    load    = 1'b1;
                    count   = TIMER_BITS'(T_RCD);
                    state_d = ACTIVATE;
                end
            end
            ACTIVATE: begin
                if (timer_done) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                if (req_head.write) begin
                    cmd     = WR;  // Data goes out with the command
                    dq_oe   = 1'b1;
                    req_deq = 1'b1;
                    state_d = IDLE;
                end else if (!rsp_full) begin  // Hold reads under back-pressure
                    cmd     = RD;
                    req_deq = 1'b1;
                    load    = 1'b1;
                    count   = TIMER_BITS'(CAS_LATENCY);
                    state_d = WAIT_CAS;
                end
            end
            WAIT_CAS: begin
                if (timer_done) begin
                    state_d = IDLE;
                end
            end
            REFRESH: begin
                if (timer_done && !ref_sent_q) begin
                    cmd   = REF;  // All banks closed by PREA
                    load  = 1'b1;
                    count = TIMER_BITS'(T_RFC);
                end else if (timer_done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign cas_hit = (state_q == WAIT_CAS) && timer_done;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state_q    <= IDLE;
            ref_sent_q <= 1'b0;
            push_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            ref_sent_q <= (state_d == REFRESH) && (ref_sent_q || cmd == REF);
            push_q     <= cas_hit;  // Response one cycle after capture
        end
    end

    always_ff @(posedge clk_in) begin
        if (cmd == RD) begin
            rsp_addr_q <= req_head.addr;  // Head moves on after the pop
        end
        if (cas_hit) begin
            rdata_q <= dq_in;
        end
    end

    assign rsp_enq  = push_q;
    assign rsp_data = '{addr: rsp_addr_q, rdata: rdata_q};
    assign dq_out   = req_head.wdata;

    // ------------------------------
    // Pin encoder
    // ------------------------------
    function automatic dram_pins_t encode_cmd(input dram_cmd_e c);
        dram_pins_t p;
        logic [2:0] rcw;  // RAS, CAS, WE
        p     = '{cs_n: 1'b0, act_n: 1'b1, bg: bg, ba: ba, addr: '0};
        rcw   = 3'b111;
        case (c)
            ACT:  p.addr[ROW_BITS-1:0] = row;  // Row on the address pins
            RD: begin
                rcw                    = 3'b101;
                p.addr[COL_BITS-1:0]   = col;
            end
            WR: begin
                rcw                    = 3'b100;
                p.addr[COL_BITS-1:0]   = col;
            end
            PRE:  rcw = 3'b010;
            PREA: begin
                rcw              = 3'b010;
                p.addr[AP_BIT]   = 1'b1;  // All banks
            end
            REF:  rcw = 3'b001;
            default: p.cs_n = 1'b1;  // NOP deselects the DIMM
        endcase
        if (c == ACT) begin
            p.act_n = 1'b0;
        end else begin
            p.addr[DRAM_ADDR_BITS-1 -: 3] = rcw;
        end
        return p;
    endfunction

    always_comb pins = encode_cmd(cmd);

    // Read data reaches the response queue a fixed time after RD
    a_rd_rsp : assert property (@(posedge clk_in) disable iff (rst_in)
        (cmd == RD) |-> ##(CAS_LATENCY + 1) rsp_enq)
        else $error("Read response not pushed CAS_LATENCY+1 cycles after RD");

endmodule : cmd_fsm

// ==== src/dram_ctrl.sv ====
// DRAM controller top level with request and response queues, bank tracker, timer and FSM
`timescale 1ns/10ps

module dram_ctrl (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          req_valid,
    input  dram_pkg::mem_req_t            req,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output dram_pkg::mem_rsp_t            rsp,
    input  logic                          rsp_ready,
    output dram_pkg::dram_pins_t          pins,       // DIMM command and address
    output logic [dram_pkg::DATA_BITS-1:0] dq_out,
    output logic                          dq_oe,
    input  logic [dram_pkg::DATA_BITS-1:0] dq_in
);

    import dram_pkg::*;

    mem_req_t              req_head;
    logic                  req_empty, req_full, req_deq;
    mem_rsp_t              rsp_data;
    logic                  rsp_enq, rsp_empty, rsp_full;
    logic [BANK_BITS-1:0]  bank;
    logic [ROW_BITS-1:0]   row;
    logic                  open, close, close_all;
    row_state_e            row_state;
    logic                  load, timer_done, refresh_due, refresh_ack;
    logic [TIMER_BITS-1:0] count;

    assign req_ready = !req_full;   // High out of reset
    assign rsp_valid = !rsp_empty;

    mem_req_queue #(.DEPTH(REQ_DEPTH), .payload_t(mem_req_t)) u_req_q (
        .clk_in(clk_in), .rst_in(rst_in),
        .enq(req_valid && req_ready), .enq_data(req), .deq(req_deq),
        .head(req_head), .empty(req_empty), .full(req_full)
    );

    mem_req_queue #(.DEPTH(RSP_DEPTH), .payload_t(mem_rsp_t)) u_rsp_q (
        .clk_in(clk_in), .rst_in(rst_in),
        .enq(rsp_enq), .enq_data(rsp_data), .deq(rsp_valid && rsp_ready),
        .head(rsp), .empty(rsp_empty), .full(rsp_full)
    );

    bank_tracker u_bank (
        .clk_in(clk_in), .rst_in(rst_in), .bank(bank), .row(row),
        .open(open), .close(close), .close_all(close_all), .row_state(row_state)
    );

    dram_timer u_timer (
        .clk_in(clk_in), .rst_in(rst_in), .load(load), .count(count),
        .refresh_ack(refresh_ack), .timer_done(timer_done), .refresh_due(refresh_due)
    );

    cmd_fsm u_fsm (
        .clk_in(clk_in), .rst_in(rst_in),
        .req_head(req_head), .req_empty(req_empty), .rsp_full(rsp_full),
        .row_state(row_state), .timer_done(timer_done), .refresh_due(refresh_due),
        .dq_in(dq_in), .req_deq(req_deq), .rsp_enq(rsp_enq), .rsp_data(rsp_data),
        .bank(bank), .row(row), .open(open), .close(close), .close_all(close_all),
        .load(load), .count(count), .refresh_ack(refresh_ack),
        .pins(pins), .dq_out(dq_out), .dq_oe(dq_oe)
    );

endmodule : dram_ctrl

// ==== src/dram_pkg.sv ====
// DRAM controller package with geometry, timing, command encodings and bus structs
package dram_pkg;

    // ------------------------------
    // Geometry
    // ------------------------------
    localparam int PADDR_BITS     = 16;                   // Physical address width
    localparam int COL_BITS       = 4;                    // Lowest address field
    localparam int BA_BITS        = 2;                    // Bank within a group
    localparam int BG_BITS        = 2;                    // Bank group
    localparam int ROW_BITS       = 8;                    // Top address field
    localparam int BANK_BITS      = BA_BITS + BG_BITS;    // Flat bank index {bg, ba}
    localparam int NUM_BANKS      = 1 << BANK_BITS;       // 16 banks
    localparam int DATA_BITS      = 64;
    localparam int DRAM_ADDR_BITS = 17;                   // A16..A0
    localparam int AP_BIT         = 10;                   // A10 selects all banks on PRE

    // ------------------------------
    // Timing in clock cycles
    // ------------------------------
    localparam int T_RP             = 3;    // PRE to ACT
    localparam int T_RCD            = 4;    // ACT to RD/WR
    localparam int CAS_LATENCY      = 5;    // RD to data on dq_in
    localparam int T_RFC            = 8;    // REF to next command
    localparam int REFRESH_INTERVAL = 200;  // Cycles between refresh requests

    // Countdown must hold the longest wait, which is T_RFC
    localparam int TIMER_BITS   = $clog2(T_RFC + 1);
    localparam int REF_CNT_BITS = $clog2(REFRESH_INTERVAL);

    localparam int REQ_DEPTH = 4;
    localparam int RSP_DEPTH = 4;

    // ------------------------------
    // Types
    // ------------------------------
    typedef enum logic [2:0] {
        NOP,
        ACT,   // Open a row
        RD,
        WR,
        PRE,   // Close one bank
        PREA,  // Close all banks
        REF
    } dram_cmd_e;

    typedef enum logic [1:0] {
        BANK_CLOSED,
        ROW_HIT,
        ROW_CONFLICT   // Bank open on another row
    } row_state_e;

    typedef struct packed {
        logic                  write;  // 1 for write, 0 for read
        logic [PADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]  wdata;
    } mem_req_t;  // 81 bits

    typedef struct packed {
        logic [PADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]  rdata;
    } mem_rsp_t;  // 80 bits

    // Non-ACT commands put active-low RAS, CAS and WE on A16..A14
    typedef struct packed {
        logic                      cs_n;
        logic                      act_n;
        logic [BG_BITS-1:0]        bg;
        logic [BA_BITS-1:0]        ba;
        logic [DRAM_ADDR_BITS-1:0] addr;
    } dram_pins_t;  // 23 bits

endpackage : dram_pkg

// ==== src/dram_timer.sv ====
// Command latency countdown and refresh interval counter with sticky due flag
`timescale 1ns/10ps

module dram_timer (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           load,        // Start a wait of count cycles
    input  logic [dram_pkg::TIMER_BITS-1:0] count,
    input  logic                           refresh_ack, // Clears refresh_due
    output logic                           timer_done,  // One-cycle pulse
    output logic                           refresh_due
);

    import dram_pkg::*;

    logic [TIMER_BITS-1:0]   cnt_q;
    logic [REF_CNT_BITS-1:0] ref_cnt_q;
    logic                    ref_wrap;

    // Countdown that holds at zero when idle
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cnt_q <= '0;
        end else if (load) begin
            cnt_q <= count;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Load of N in cycle c gives done in cycle c+N
    assign timer_done = (cnt_q == TIMER_BITS'(1));

    // ------------------------------
    // Refresh interval
    // ------------------------------
    assign ref_wrap = (ref_cnt_q == REF_CNT_BITS'(REFRESH_INTERVAL - 1));

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            ref_cnt_q   <= '0;
            refresh_due <= 1'b0;
        end else begin
            ref_cnt_q <= ref_wrap ? '0 : ref_cnt_q + 1'b1;  // Free running
            if (ref_wrap) begin
                refresh_due <= 1'b1;  // New interval wins over an ack
            end else if (refresh_ack) begin
                refresh_due <= 1'b0;
            end
        end
    end

    // A new wait never cuts a running one short
    a_load_free : assert property (@(posedge clk_in) disable iff (rst_in) load |-> cnt_q <= 1)
        else $error("Timer reloaded before its wait ran out");
    a_ack_due : assert property (@(posedge clk_in) disable iff (rst_in) refresh_ack |-> refresh_due)
        else $error("Refresh acknowledged while none was due");

endmodule : dram_timer

// ==== src/mem_req_queue.sv ====
// Circular FIFO with a payload type parameter and overflow/underflow checks
`timescale 1ns/10ps

module mem_req_queue #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     enq,       // Push enq_data
    input  payload_t enq_data,
    input  logic     deq,       // Pop head
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            mem_q [DEPTH];  // Storage
    logic [PTR_BITS-1:0] head_q;         // Oldest entry
    logic [CNT_BITS-1:0] count_q;        // Entries held
    logic [PTR_BITS-1:0] tail;           // Next free slot

    assign tail = PTR_BITS'((int'(head_q) + int'(count_q)) % DEPTH);

    // Pointer and count
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            head_q  <= '0;
            count_q <= '0;
        end else begin
            if (deq) begin
                head_q <= (head_q == PTR_BITS'(DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            case ({enq, deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (enq) begin
            mem_q[tail] <= enq_data;
        end
    end

    assign head  = mem_q[head_q];  // Valid on the cycle after the push
    assign empty = (count_q == '0);
    assign full  = (count_q == CNT_BITS'(DEPTH));

    a_no_overflow : assert property (@(posedge clk_in) disable iff (rst_in) !(enq && full))
        else $error("Push into a full queue");
    a_no_underflow : assert property (@(posedge clk_in) disable iff (rst_in) !(deq && empty))
        else $error("Pop from an empty queue");

endmodule : mem_req_queue

// ==== tb.f ====
src/dram_pkg.sv
src/mem_req_queue.sv
src/bank_tracker.sv
src/dram_timer.sv
src/cmd_fsm.sv
src/dram_ctrl.sv
verification/dimm_model.sv
verification/tb_dram_ctrl.sv

// ==== verification/dimm_model.sv ====
// Behavioral DIMM with data storage, command legality and timing checks, and read data return
`timescale 1ns/10ps

module dimm_model (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  dram_pkg::dram_pins_t           pins,
    input  logic [dram_pkg::DATA_BITS-1:0]  dq_out,
    input  logic                           dq_oe,
    output logic [dram_pkg::DATA_BITS-1:0]  dq_in,
    output dram_pkg::dram_cmd_e            cmd,      // Decoded command on the pins
    output int                             err_cnt   // Protocol violations seen
);

    import dram_pkg::*;

    localparam logic [DATA_BITS-1:0] JUNK = {4{16'hbad0}};  // Bus value outside the data slot

    logic [DATA_BITS-1:0]  mem [logic [PADDR_BITS-1:0]];  // Sparse storage
    logic [NUM_BANKS-1:0]  open_q;
    logic [ROW_BITS-1:0]   row_q [NUM_BANKS];
    logic [BANK_BITS-1:0]  bank;
    logic [PADDR_BITS-1:0] addr;                         // Rebuilt physical address
    logic [DATA_BITS-1:0]  dq_q = JUNK;
    logic [DATA_BITS-1:0]  rd_data;
    int                    cyc, ready_cyc, rd_wait;

    assign bank  = {pins.bg, pins.ba};
    assign addr  = {row_q[bank], bank, pins.addr[COL_BITS-1:0]};  // Row, bg, ba, column
    assign dq_in = dq_q;

    // RAS, CAS and WE live on A16..A14
    always_comb begin
        cmd = NOP;
        if (!pins.cs_n && !pins.act_n) begin
            cmd = ACT;
        end else if (!pins.cs_n) begin
            case (pins.addr[DRAM_ADDR_BITS-1 -: 3])
                3'b101:  cmd = RD;
                3'b100:  cmd = WR;
                3'b010:  cmd = pins.addr[AP_BIT] ? PREA : PRE;
                3'b001:  cmd = REF;
                default: cmd = NOP;
            endcase
        end
    end

    task automatic flag_violation(input string msg);
        $display("ERROR: %0t ns DIMM saw %s", $time, msg);
        err_cnt++;
    endtask

    always @(negedge clk_in) begin
        if (rst_in) begin
            open_q  = '0;  // All banks idle
            rd_wait = 0;
            dq_q    = JUNK;
        end else begin
            cyc++;
            // ------------------------------
            // Read data slot
            // ------------------------------
            dq_q = (rd_wait == 1) ? rd_data : JUNK;  // Valid CAS_LATENCY cycles after RD
            if (rd_wait != 0) begin
                rd_wait--;
            end
            if (dq_oe && cmd != WR) begin
                flag_violation("dq_oe high without a WR command");
            end
            if (cmd != NOP && cyc < ready_cyc) begin
                flag_violation($sformatf("%s sooner than the previous command allows", cmd.name()));
            end
            if (cmd != NOP) begin
                ready_cyc = cyc + 1;
            end
            case (cmd)
                ACT: begin
                    if (open_q[bank]) begin
                        flag_violation("ACT to a bank that is already open");
                    end
                    open_q[bank] = 1'b1;
                    row_q[bank]  = pins.addr[ROW_BITS-1:0];
                    ready_cyc    = cyc + T_RCD;
                end
                RD, WR: begin
                    if (!open_q[bank]) begin
                        flag_violation($sformatf("%s to a closed bank", cmd.name()));
                    end
                    if (cmd == WR) begin
                        if (!dq_oe) begin
                            flag_violation("WR command without dq_oe high");
                        end
                        mem[addr] = dq_out;  // Data rides with the command
                    end else begin
                        rd_data = mem.exists(addr) ? mem[addr] : '0;
                        rd_wait = CAS_LATENCY;
                    end
                end
                PRE: begin
                    open_q[bank] = 1'b0;
                    ready_cyc    = cyc + T_RP;
                end
                PREA: begin
                    open_q    = '0;
                    ready_cyc = cyc + T_RP;
                end
                REF: begin
                    if (open_q != '0) begin
                        flag_violation("REF while a bank is open");
                    end
                    ready_cyc = cyc + T_RFC;
                end
                default: ;
            endcase
        end
    end

endmodule : dimm_model

// ==== verification/tb_dram_ctrl.sv ====
// Testbench for the DRAM controller with random requests, memory and row models, and watchdog
`timescale 1ns/10ps

module tb_dram_ctrl;

    import dram_pkg::*;

    localparam int NUM_REQ   = 300;
    localparam int CLK_NS    = 4;
    localparam int REF_LIMIT = REFRESH_INTERVAL + 40;  // Longest allowed gap between REFs

    logic                 clk_in    = 1'b0;
    logic                 rst_in    = 1'b1;
    logic                 req_valid = 1'b0;
    mem_req_t             req       = '0;
    logic                 rsp_ready = 1'b0;
    logic                 req_ready, rsp_valid, dq_oe;
    mem_rsp_t             rsp;
    dram_pins_t           pins;
    logic [DATA_BITS-1:0] dq_out, dq_in;
    dram_cmd_e            cmd;
    int                   dimm_errs;

    int       seed = 40404;
    int       errs, sent, rd_sent, rsp_cnt, ref_cnt, cyc, last_ref;
    bit       go, have_req;
    mem_req_t cur;
    logic [DATA_BITS-1:0] model_mem [logic [PADDR_BITS-1:0]];  // Last write per address
    mem_rsp_t exp_q [$];                                      // Reads in acceptance order
    mem_req_t svc_q [$];                                      // All requests in service order
    logic [NUM_BANKS-1:0] tab_open  = '0;
    logic [NUM_BANKS-1:0] snap_open = '0;                     // Table at end of last access
    logic [ROW_BITS-1:0]  tab_row [NUM_BANKS];
    logic [ROW_BITS-1:0]  snap_row [NUM_BANKS];
    int       n_act, n_pre;                                   // Since the last access

    always #(CLK_NS / 2) clk_in = ~clk_in;

    dram_ctrl u_dram_ctrl (
        .clk_in(clk_in), .rst_in(rst_in), .req_valid(req_valid), .req(req),
        .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready),
        .pins(pins), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
    );

    dimm_model u_dimm (
        .clk_in(clk_in), .rst_in(rst_in), .pins(pins), .dq_out(dq_out), .dq_oe(dq_oe),
        .dq_in(dq_in), .cmd(cmd), .err_cnt(dimm_errs)
    );

    task automatic compare_value(input string name, input logic [DATA_BITS-1:0] exp,
                                 input logic [DATA_BITS-1:0] act);
        if (exp !== act) begin
            $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            errs++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("ERROR: %0t ns %s", $time, msg);
        errs++;
    endtask

    // Small row and bank pools so hits and conflicts both show up
    function automatic mem_req_t random_request();
        mem_req_t r;
        r.write = 1'($random(seed));
        r.addr  = {ROW_BITS'(({$random(seed)} % 4) * 85), BANK_BITS'(({$random(seed)} % 4) * 5),
                   COL_BITS'({$random(seed)} % 4)};
        r.wdata = {$random(seed), $random(seed)};
        return r;
    endfunction

    task automatic accept(input mem_req_t r);
        mem_rsp_t e;
        svc_q.push_back(r);
        if (r.write) begin
            model_mem[r.addr] = r.wdata;
        end else begin
            e.addr  = r.addr;
            e.rdata = model_mem.exists(r.addr) ? model_mem[r.addr] : '0;  // Never written reads 0
            exp_q.push_back(e);
            rd_sent++;
        end
        sent++;
    endtask

    task automatic take_response();
        mem_rsp_t e;
        if (exp_q.size() == 0) begin
            note_error("response arrived with no read outstanding");
        end else begin
            e = exp_q.pop_front();
            compare_value("rsp.addr", DATA_BITS'(e.addr), DATA_BITS'(rsp.addr));
            compare_value("rsp.rdata", e.rdata, rsp.rdata);
        end
        rsp_cnt++;
    endtask

    // ------------------------------
    // Row policy and refresh monitor
    // ------------------------------
    task automatic watch_command();
        mem_req_t             r;
        logic [BANK_BITS-1:0] b;
        logic [ROW_BITS-1:0]  rrow;
        int                   want_pre, want_act;
        b = {pins.bg, pins.ba};
        case (cmd)
            ACT: begin
                tab_open[b] = 1'b1;
                tab_row[b]  = pins.addr[ROW_BITS-1:0];
                n_act++;
            end
            PRE: begin
                tab_open[b] = 1'b0;
                n_pre++;
            end
            PREA: tab_open = '0;
            REF: begin
                if (cyc - last_ref > REF_LIMIT) begin
                    note_error($sformatf("REF gap of %0d cycles is too long", cyc - last_ref));
                end
                last_ref  = cyc;
                ref_cnt++;
                snap_open = tab_open;  // Next request starts from all closed
                snap_row  = tab_row;
            end
            RD, WR: begin
                if (svc_q.size() == 0) begin
                    note_error("RD or WR issued with no request in service");
                end else begin
                    r    = svc_q.pop_front();
                    rrow = r.addr[PADDR_BITS-1 -: ROW_BITS];
                    compare_value("WR command", DATA_BITS'(r.write), DATA_BITS'(cmd == WR));
                    compare_value("pins bank", DATA_BITS'(r.addr[COL_BITS +: BANK_BITS]),
                                  DATA_BITS'(b));
                    compare_value("pins column", DATA_BITS'(r.addr[COL_BITS-1:0]),
                                  DATA_BITS'(pins.addr[COL_BITS-1:0]));
                    compare_value("open row", DATA_BITS'(rrow), DATA_BITS'(tab_row[b]));
                    if (!snap_open[b]) begin
                        want_pre = 0;  // Bank closed
                        want_act = 1;
                    end else if (snap_row[b] == rrow) begin
                        want_pre = 0;  // Row hit
                        want_act = 0;
                    end else begin
                        want_pre = 1;  // Conflict
                        want_act = 1;
                    end
                    compare_value("PRE count", DATA_BITS'(want_pre), DATA_BITS'(n_pre));
                    compare_value("ACT count", DATA_BITS'(want_act), DATA_BITS'(n_act));
                    n_act     = 0;
                    n_pre     = 0;
                    snap_open = tab_open;
                    snap_row  = tab_row;
                end
            end
            default: ;
        endcase
    endtask

    // Outputs are stable here, inputs change for the coming rising edge
    always @(negedge clk_in) begin
        if (go) begin
            cyc++;
            watch_command();
            rsp_ready = ($random(seed) & 3) != 0;  // Low a quarter of the time
            if (rsp_valid && rsp_ready) begin
                take_response();
            end
            if (!have_req && sent < NUM_REQ) begin
                cur      = random_request();
                have_req = 1'b1;
            end
            req_valid = have_req;  // Held until accepted
            req       = cur;
            if (have_req && req_ready) begin
                accept(cur);
                have_req = 1'b0;
            end
        end
    end

    initial begin
        repeat (4) @(negedge clk_in);
        rst_in = 1'b0;
        compare_value("req_ready", DATA_BITS'(1'b1), DATA_BITS'(req_ready));
        compare_value("rsp_valid", DATA_BITS'(1'b0), DATA_BITS'(rsp_valid));
        compare_value("dq_oe", DATA_BITS'(1'b0), DATA_BITS'(dq_oe));
        compare_value("pins.cs_n", DATA_BITS'(1'b1), DATA_BITS'(pins.cs_n));
        @(posedge clk_in);
        go = 1'b1;
        while (!(sent == NUM_REQ && svc_q.size() == 0 && rsp_cnt >= rd_sent)) begin
            @(posedge clk_in);
        end
        repeat (4 * CAS_LATENCY) @(posedge clk_in);  // Room for a stray extra response
        compare_value("response count", DATA_BITS'(rd_sent), DATA_BITS'(rsp_cnt));
        if (ref_cnt == 0) begin
            note_error("no REF command was issued during the run");
        end
        $display("Error counts: testbench %0d, DIMM %0d (%0d requests, %0d reads, %0d refreshes)",
                 errs, dimm_errs, sent, rd_sent, ref_cnt);
        if (errs + dimm_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the request count
    initial begin
        #(NUM_REQ * 40 * CLK_NS);
        $display("Timeout: run did not complete within %0d ns", NUM_REQ * 40 * CLK_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule : tb_dram_ctrl
